// File: hw/udp_echo_defs.svh
// UDP echo shared constants
// Buffer geometry, header word layout and LED thresholds
`ifndef UDP_ECHO_DEFS_SVH
`define UDP_ECHO_DEFS_SVH

// Both buffers hold 64 words of 32 bits
`define UDP_BUF_AWIDTH 6

// Receive buffer layout
`define RX_IP_WORD      0
`define RX_LEN_WORD     1
`define RX_SPORT_WORD   2
`define RX_PAYLOAD_BASE 3

// Transmit buffer layout
`define TX_IP_WORD      0
`define TX_PORT_WORD    1
`define TX_LEN_WORD     2
`define TX_PAYLOAD_BASE 3

`define UDP_HDR_BYTES 8

// Payload byte thresholds for led4 to led7
`define LED_LEVEL1 1
`define LED_LEVEL2 5
`define LED_LEVEL3 10
`define LED_LEVEL4 15

`endif

// File: hw/udp_echo_pkg.sv
// UDP echo package
// State types of the receive store and the transmit scheduler
`default_nettype none

package udp_echo_pkg;

    // Receive buffer ownership
    typedef enum logic [1:0] {
        RX_EMPTY,
        RX_HELD,
        RX_RELEASE
    } rx_state_t;

    // Transmit request sequence
    typedef enum logic [1:0] {
        TX_IDLE,
        TX_REQUEST,
        TX_WAIT
    } tx_state_t;

endpackage

`default_nettype wire

// File: hw/rx_payload_if.sv
// Stored datagram view
// The store publishes the captured header and answers word reads
`default_nettype none
`include "udp_echo_defs.svh"

interface rx_payload_if;

    logic [31:0]                src_ip;
    logic [15:0]                src_port;
    logic [15:0]                dst_port;
    logic [15:0]                payload_len;
    logic [`UDP_BUF_AWIDTH-1:0] rd_addr;
    logic [31:0]                rd_data;

    modport store (
        output src_ip,
        output src_port,
        output dst_port,
        output payload_len,
        output rd_data,
        input  rd_addr
    );

    modport composer (
        input  src_ip,
        input  src_port,
        input  dst_port,
        input  payload_len,
        input  rd_data,
        output rd_addr
    );

endinterface

`default_nettype wire

// File: hw/udp_rx_store.sv
// UDP receive store
// Holds one datagram, shows its payload size on LEDs, returns the buffer after the echo
`default_nettype none
`include "udp_echo_defs.svh"

module udp_rx_store (
    input  logic                       clk_int,
    input  logic                       rst_n_int,
    input  logic                       rxbuf_ce,
    input  logic                       rxbuf_we,
    input  logic                       rxbuf_grant,
    input  logic [`UDP_BUF_AWIDTH-1:0] rxbuf_addr,
    input  logic [31:0]                rxbuf_wdata,
    output logic                       rxbuf_rel,
    input  logic                       tx_done,
    output logic                       new_pkt,
    output logic [3:0]                 leds,
    rx_payload_if.store                pay
);

    // Largest UDP length whose payload still fits behind the header words
    localparam int max_udp_len =
        `UDP_HDR_BYTES + 4 * ((1 << `UDP_BUF_AWIDTH) - `RX_PAYLOAD_BASE);

    logic [31:0]             mem [0:(1 << `UDP_BUF_AWIDTH)-1];
    udp_echo_pkg::rx_state_t rx_state;
    logic [15:0]             udp_len;
    logic [15:0]             payload_len;
    logic                    wr_en;
    logic                    accept;

    assign wr_en  = rxbuf_ce && rxbuf_we && (rx_state == udp_echo_pkg::RX_EMPTY);
    assign accept = rxbuf_grant && (rx_state == udp_echo_pkg::RX_EMPTY);

    always_ff @(posedge clk_int) begin
        if (wr_en) begin
            mem[rxbuf_addr] <= rxbuf_wdata;
        end
    end

    // Composer read port
    assign pay.rd_data = mem[pay.rd_addr];

    always_ff @(posedge clk_int) begin
        if (accept) begin
            pay.src_ip   <= mem[`RX_IP_WORD];
            pay.dst_port <= mem[`RX_LEN_WORD][15:0];
            pay.src_port <= mem[`RX_SPORT_WORD][15:0];
        end
    end

    always_ff @(posedge clk_int or negedge rst_n_int) begin
        if (!rst_n_int) begin
            rx_state <= udp_echo_pkg::RX_EMPTY;
            udp_len  <= 16'(`UDP_HDR_BYTES);
            new_pkt  <= 1'b0;
        end else begin
            new_pkt <= accept;
            if (accept) begin
                udp_len <= mem[`RX_LEN_WORD][31:16];
            end
            case (rx_state)
                udp_echo_pkg::RX_EMPTY: begin
                    if (rxbuf_grant) begin
                        rx_state <= udp_echo_pkg::RX_HELD;
                    end
                end
                udp_echo_pkg::RX_HELD: begin
                    if (tx_done) begin
                        rx_state <= udp_echo_pkg::RX_RELEASE;
                    end
                end
                default: begin
                    rx_state <= udp_echo_pkg::RX_EMPTY;
                end
            endcase
        end
    end

    // One-cycle handback, the engine may refill once it is seen
    assign rxbuf_rel = (rx_state == udp_echo_pkg::RX_RELEASE);

    assign payload_len     = udp_len - 16'(`UDP_HDR_BYTES);
    assign pay.payload_len = payload_len;

    // Level meter, led4 in bit 0
    assign leds[0] = (payload_len >= 16'(`LED_LEVEL1));
    assign leds[1] = (payload_len >= 16'(`LED_LEVEL2));
    assign leds[2] = (payload_len >= 16'(`LED_LEVEL3));
    assign leds[3] = (payload_len >= 16'(`LED_LEVEL4));

    a_write_when_empty: assert property (
        @(posedge clk_int) disable iff (!rst_n_int)
        (rxbuf_ce && rxbuf_we) |-> (rx_state == udp_echo_pkg::RX_EMPTY)
    ) else $error("rx buffer written while a datagram is held");

    a_grant_when_empty: assert property (
        @(posedge clk_int) disable iff (!rst_n_int)
        rxbuf_grant |-> (rx_state == udp_echo_pkg::RX_EMPTY)
    ) else $error("rx grant before the buffer was released");

    // Captured length must leave a payload that fits the buffer
    a_udp_len_range: assert property (
        @(posedge clk_int) disable iff (!rst_n_int)
        accept |=> (udp_len >= 16'(`UDP_HDR_BYTES)) && (udp_len <= 16'(max_udp_len))
    ) else $error("udp length %0d out of range", udp_len);

endmodule

`default_nettype wire

// File: hw/udp_tx_sched.sv
// UDP transmit scheduler
// Requests one send per stored datagram and reports its completion
`default_nettype none

module udp_tx_sched (
    input  logic clk_int,
    input  logic rst_n_int,
    input  logic new_pkt,
    input  logic txbuf_grant,
    output logic txbuf_rel,
    output logic tx_done
);

    udp_echo_pkg::tx_state_t tx_state;

    always_ff @(posedge clk_int or negedge rst_n_int) begin
        if (!rst_n_int) begin
            tx_state <= udp_echo_pkg::TX_IDLE;
            tx_done  <= 1'b0;
        end else begin
            tx_done <= 1'b0;
            case (tx_state)
                udp_echo_pkg::TX_IDLE: begin
                    if (new_pkt) begin
                        tx_state <= udp_echo_pkg::TX_REQUEST;
                    end
                end
                udp_echo_pkg::TX_REQUEST: begin
                    tx_state <= udp_echo_pkg::TX_WAIT;
                end
                udp_echo_pkg::TX_WAIT: begin
                    // Engine signals the send is finished
                    if (txbuf_grant) begin
                        tx_state <= udp_echo_pkg::TX_IDLE;
                        tx_done  <= 1'b1;
                    end
                end
                default: begin
                    tx_state <= udp_echo_pkg::TX_IDLE;
                end
            endcase
        end
    end

    // Hands the tx buffer to the engine for one cycle
    assign txbuf_rel = (tx_state == udp_echo_pkg::TX_REQUEST);

    a_grant_in_wait: assert property (
        @(posedge clk_int) disable iff (!rst_n_int)
        txbuf_grant |-> (tx_state == udp_echo_pkg::TX_WAIT)
    ) else $error("tx grant without an outstanding request");

    // Store must not hand over a second datagram mid-send
    a_new_pkt_in_idle: assert property (
        @(posedge clk_int) disable iff (!rst_n_int)
        new_pkt |-> (tx_state == udp_echo_pkg::TX_IDLE)
    ) else $error("new datagram while a send is in progress");

endmodule

`default_nettype wire

// File: hw/udp_tx_composer.sv
// UDP echo reply composer
// Answers tx buffer reads with the reply header and the stored payload
`default_nettype none
`include "udp_echo_defs.svh"

module udp_tx_composer (
    input  logic [`UDP_BUF_AWIDTH-1:0] txbuf_addr,
    output logic [31:0]                txbuf_rdata,
    rx_payload_if.composer             pay
);

    logic [15:0] len_round;
    logic [15:0] pay_words;
    logic [15:0] addr_ext;
    logic        in_payload;

    // Payload words, rounded up to whole words
    assign len_round = pay.payload_len + 16'd3;
    assign pay_words = {2'b00, len_round[15:2]};

    assign addr_ext   = 16'(txbuf_addr);
    assign in_payload = (addr_ext >= 16'(`TX_PAYLOAD_BASE)) &&
                        (addr_ext < 16'(`TX_PAYLOAD_BASE) + pay_words);

    // Same payload offset in both buffers
    assign pay.rd_addr = txbuf_addr + `UDP_BUF_AWIDTH'(`RX_PAYLOAD_BASE)
                                    - `UDP_BUF_AWIDTH'(`TX_PAYLOAD_BASE);

    always_comb begin
        case (txbuf_addr)
            `UDP_BUF_AWIDTH'(`TX_IP_WORD): begin
                txbuf_rdata = pay.src_ip;
            end
            `UDP_BUF_AWIDTH'(`TX_PORT_WORD): begin
                // Reply leaves from the port it was sent to
                txbuf_rdata = {pay.dst_port, pay.src_port};
            end
            `UDP_BUF_AWIDTH'(`TX_LEN_WORD): begin
                txbuf_rdata = {16'h0000, pay.payload_len};
            end
            default: begin
                if (in_payload) begin
                    txbuf_rdata = pay.rd_data;
                end else begin
                    txbuf_rdata = 32'h0000_0000;
                end
            end
        endcase
    end

endmodule

`default_nettype wire

// File: hw/udp_echo_top.sv
// UDP echo responder top level
// Stores each datagram from the engine and sends it back to its sender
`default_nettype none
`include "udp_echo_defs.svh"

module udp_echo_top (
    input  logic                       clk_int,
    input  logic                       rst_n_int,

    input  logic                       rxbuf_ce,
    input  logic                       rxbuf_we,
    input  logic [`UDP_BUF_AWIDTH-1:0] rxbuf_addr,
    input  logic [31:0]                rxbuf_wdata,
    input  logic                       rxbuf_grant,
    output logic                       rxbuf_rel,

    input  logic [`UDP_BUF_AWIDTH-1:0] txbuf_addr,
    output logic [31:0]                txbuf_rdata,
    input  logic                       txbuf_grant,
    output logic                       txbuf_rel,

    output logic                       led4,
    output logic                       led5,
    output logic                       led6,
    output logic                       led7
);

    logic       new_pkt;
    logic       tx_done;
    logic [3:0] leds;

    rx_payload_if pay_if ();

    udp_rx_store u_rx_store (
        .clk_int     (clk_int),
        .rst_n_int   (rst_n_int),
        .rxbuf_ce    (rxbuf_ce),
        .rxbuf_we    (rxbuf_we),
        .rxbuf_grant (rxbuf_grant),
        .rxbuf_addr  (rxbuf_addr),
        .rxbuf_wdata (rxbuf_wdata),
        .rxbuf_rel   (rxbuf_rel),
        .tx_done     (tx_done),
        .new_pkt     (new_pkt),
        .leds        (leds),
        .pay         (pay_if.store)
    );

    udp_tx_sched u_tx_sched (
        .clk_int     (clk_int),
        .rst_n_int   (rst_n_int),
        .new_pkt     (new_pkt),
        .txbuf_grant (txbuf_grant),
        .txbuf_rel   (txbuf_rel),
        .tx_done     (tx_done)
    );

    udp_tx_composer u_tx_composer (
        .txbuf_addr  (txbuf_addr),
        .txbuf_rdata (txbuf_rdata),
        .pay         (pay_if.composer)
    );

    assign led4 = leds[0];
    assign led5 = leds[1];
    assign led6 = leds[2];
    assign led7 = leds[3];

endmodule

`default_nettype wire

// File: testbench/tb_udp_echo.sv
// UDP echo testbench
// Models the UDP engine, sends random datagrams and checks every echo reply
`default_nettype none
`include "udp_echo_defs.svh"

module tb_udp_echo;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int clk_half      = 50;
    localparam int buf_words     = 1 << `UDP_BUF_AWIDTH;
    localparam int max_pay_bytes = 4 * (buf_words - `RX_PAYLOAD_BASE);
    localparam int num_pkts      = 40;
    localparam int num_directed  = 6;
    // Writes, reply sweep, engine delay and handshakes of the longest datagram
    localparam int pkt_cycles    = 64 + 64 + 16 + 10;
    localparam int cycle_limit   = 16 + num_pkts * pkt_cycles + 200;

    logic                       clk_int;
    logic                       rst_n_int;
    logic                       rxbuf_ce;
    logic                       rxbuf_we;
    logic [`UDP_BUF_AWIDTH-1:0] rxbuf_addr;
    logic [31:0]                rxbuf_wdata;
    logic                       rxbuf_grant;
    logic                       rxbuf_rel;
    logic [`UDP_BUF_AWIDTH-1:0] txbuf_addr;
    logic [31:0]                txbuf_rdata;
    logic                       txbuf_grant;
    logic                       txbuf_rel;
    logic                       led4;
    logic                       led5;
    logic                       led6;
    logic                       led7;

    logic [31:0] lfsr = 32'h3674;
    logic [31:0] sent  [0:buf_words-1];
    logic [31:0] reply [0:buf_words-1];
    int          errors    = 0;
    int          checks    = 0;
    int          cycles    = 0;
    int          rel_count = 0;

    udp_echo_top u_dut (
        .clk_int     (clk_int),
        .rst_n_int   (rst_n_int),
        .rxbuf_ce    (rxbuf_ce),
        .rxbuf_we    (rxbuf_we),
        .rxbuf_addr  (rxbuf_addr),
        .rxbuf_wdata (rxbuf_wdata),
        .rxbuf_grant (rxbuf_grant),
        .rxbuf_rel   (rxbuf_rel),
        .txbuf_addr  (txbuf_addr),
        .txbuf_rdata (txbuf_rdata),
        .txbuf_grant (txbuf_grant),
        .txbuf_rel   (txbuf_rel),
        .led4        (led4),
        .led5        (led5),
        .led6        (led6),
        .led7        (led7)
    );

    initial clk_int = 1'b0;
    always #(clk_half) clk_int = ~clk_int;

    // Fibonacci LFSR, taps 32 22 2 1, one step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            v    = {v[30:0], fb};
        end
        return v;
    endfunction

    function automatic int directed_len(input int idx);
        case (idx)
            0:       return 0;
            1:       return 4;
            2:       return 5;
            3:       return 14;
            4:       return 15;
            default: return max_pay_bytes;
        endcase
    endfunction

    task automatic expect_eq(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("** Error: %s got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    // Expected transmit buffer, ports swapped, zero past the payload
    task automatic build_reply(input logic [31:0] ip, input logic [15:0] sport,
                               input logic [15:0] dport, input int len);
        int last;
        last = `TX_PAYLOAD_BASE + (len + 3) / 4 - 1;
        for (int a = 0; a < buf_words; a++) begin
            reply[a] = 32'h0;
        end
        reply[0] = ip;
        reply[1] = {dport, sport};
        reply[2] = 32'(len);
        for (int a = `TX_PAYLOAD_BASE; a <= last; a++) begin
            reply[a] = sent[a];
        end
    endtask

    task automatic send_datagram(input int pkt, input int len);
        logic [31:0] ip;
        logic [15:0] sport;
        logic [15:0] dport;
        logic [3:0]  exp_leds;
        int          last;
        int          delay;
        ip    = rand_bits(32);
        sport = 16'(rand_bits(16));
        dport = 16'(rand_bits(16));
        last  = `RX_PAYLOAD_BASE + (len + 3) / 4 - 1;
        sent[0] = ip;
        sent[1] = {16'(len + `UDP_HDR_BYTES), dport};
        sent[2] = {16'(rand_bits(16)), sport};
        for (int a = `RX_PAYLOAD_BASE; a <= last; a++) begin
            sent[a] = rand_bits(32);
        end
        for (int a = 0; a <= last; a++) begin
            @(negedge clk_int);
            rxbuf_ce    = 1'b1;
            rxbuf_we    = 1'b1;
            rxbuf_addr  = `UDP_BUF_AWIDTH'(a);
            rxbuf_wdata = sent[a];
        end
        @(negedge clk_int);
        rxbuf_ce    = 1'b0;
        rxbuf_we    = 1'b0;
        rxbuf_grant = 1'b1;
        @(negedge clk_int);
        rxbuf_grant = 1'b0;
        exp_leds = {len >= `LED_LEVEL4, len >= `LED_LEVEL3,
                    len >= `LED_LEVEL2, len >= `LED_LEVEL1};
        expect_eq("leds", 32'({led7, led6, led5, led4}), 32'(exp_leds));
        expect_eq("txbuf_rel", 32'(txbuf_rel), 32'h0);
        // Request comes on the second edge after the grant
        @(negedge clk_int);
        expect_eq("txbuf_rel", 32'(txbuf_rel), 32'h1);
        @(negedge clk_int);
        expect_eq("txbuf_rel", 32'(txbuf_rel), 32'h0);
        build_reply(ip, sport, dport, len);
        for (int a = 0; a < buf_words; a++) begin
            txbuf_addr = `UDP_BUF_AWIDTH'(a);
            #(clk_half / 2);
            expect_eq($sformatf("txbuf_rdata[%0d]", a), txbuf_rdata, reply[a]);
            @(negedge clk_int);
        end
        expect_eq("rxbuf_rel pulses", 32'(rel_count), 32'(pkt));
        delay = int'(rand_bits(4));
        repeat (delay) @(negedge clk_int);
        txbuf_grant = 1'b1;
        @(negedge clk_int);
        txbuf_grant = 1'b0;
        expect_eq("rxbuf_rel", 32'(rxbuf_rel), 32'h0);
        @(negedge clk_int);
        expect_eq("rxbuf_rel", 32'(rxbuf_rel), 32'h1);
        @(negedge clk_int);
        expect_eq("rxbuf_rel", 32'(rxbuf_rel), 32'h0);
        expect_eq("rxbuf_rel pulses", 32'(rel_count), 32'(pkt + 1));
    endtask

    always @(posedge clk_int) begin
        if (rst_n_int && rxbuf_rel) begin
            rel_count <= rel_count + 1;
        end
    end

    always @(posedge clk_int) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("Timeout: no end of test after %0d cycles, errors %0d, checks %0d",
                     cycle_limit, errors, checks);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    initial begin
        int len;
        rst_n_int   = 1'b0;
        rxbuf_ce    = 1'b0;
        rxbuf_we    = 1'b0;
        rxbuf_addr  = '0;
        rxbuf_wdata = 32'h0;
        rxbuf_grant = 1'b0;
        txbuf_addr  = '0;
        txbuf_grant = 1'b0;
        repeat (16) @(negedge clk_int);
        rst_n_int = 1'b1;
        @(negedge clk_int);
        expect_eq("leds", 32'({led7, led6, led5, led4}), 32'h0);
        expect_eq("txbuf_rel", 32'(txbuf_rel), 32'h0);
        expect_eq("rxbuf_rel", 32'(rxbuf_rel), 32'h0);
        for (int pkt = 0; pkt < num_pkts; pkt++) begin
            if (pkt < num_directed) begin
                len = directed_len(pkt);
            end else begin
                len = int'(rand_bits(8) % (max_pay_bytes + 1));
            end
            send_datagram(pkt, len);
        end
        repeat (4) @(negedge clk_int);
        expect_eq("rxbuf_rel pulses", 32'(rel_count), 32'(num_pkts));
        $display("Summary: %0d datagrams, %0d checks, %0d errors", num_pkts, checks, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: list.f
+incdir+hw
hw/udp_echo_pkg.sv
hw/rx_payload_if.sv
hw/udp_rx_store.sv
hw/udp_tx_sched.sv
hw/udp_tx_composer.sv
hw/udp_echo_top.sv
testbench/tb_udp_echo.sv

// File: Makefile
# Verilator simulation of the UDP echo responder

VERILATOR ?= verilator
TOP       ?= tb_udp_echo
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= PASS: all tests

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) | tee $(LOG)
	@if grep -qxF "$(PASS_MSG)" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
